/* common/pipeAlu_settings.svh */
// ********************
// build-wide sizes for the pipelined ALU
// include wherever a width or the register count is needed
// ********************

`ifndef PIPEALU_SETTINGS_SVH
`define PIPEALU_SETTINGS_SVH

// width of one data word in bits
// the SRA opcode keeps the top bit of this word
`define PIPEALU_DATA_WIDTH 8

// number of architectural registers
// register address width is derived from this in the package
`define PIPEALU_REG_COUNT 4

`endif

/* common/pipeAluPkg.sv */
// ********************
// shared types of the pipelined ALU
// modules import it inside their body, ports use scoped names
// ********************

`default_nettype none

`include "pipeAlu_settings.svh"

package pipeAluPkg;

    // one data word, as held in the register file
    typedef logic [`PIPEALU_DATA_WIDTH-1:0] dataT;

    // register index, sized from the register count
    typedef logic [$clog2(`PIPEALU_REG_COUNT)-1:0] regAddrT;

    // ALU function select
    typedef enum logic [2:0] {
        opAdd  = 3'd0, // op1 + op2, wraps
        opSub  = 3'd1, // op1 - op2, wraps
        opOne  = 3'd2, // constant one
        opAnd  = 3'd3, // op1 & op2
        opNand = 3'd4, // ~(op1 & op2)
        opSrl  = 3'd5, // logical shift right by one
        opSra  = 3'd6, // arithmetic shift right by one
        opCpa  = 3'd7  // copy op1
    } aluOpT;

endpackage

`default_nettype wire

/* common/operandBus.sv */
// ********************
// decoded instruction passed from decode to execute
// decode drives it through the decoder modport, execute reads it
// ********************

`default_nettype none

interface operandBus;
    import pipeAluPkg::*;

    logic    valid; // instruction present, low for a bubble
    aluOpT   op;    // ALU function
    dataT    op1;   // first operand, bypass already applied
    dataT    op2;   // second operand
    regAddrT dest;  // destination register

    // decode side owns the execute input register
    modport decoder (
        output valid,
        output op,
        output op1,
        output op2,
        output dest
    );

    // execute side only consumes
    modport executor (
        input valid,
        input op,
        input op1,
        input op2,
        input dest
    );

endinterface

`default_nettype wire

/* pipeAlu/operandDecode.sv */
// ********************
// decode stage with operand read and bypass from the result register
// read-after-write stall against execute and the execute input register
// ********************

`default_nettype none

module operandDecode (
    input  logic                clock,
    input  logic                rstN,
    input  logic                issueValid,
    input  pipeAluPkg::aluOpT   opcode,
    input  pipeAluPkg::regAddrT src1,
    input  pipeAluPkg::regAddrT src2,
    input  pipeAluPkg::regAddrT dest,
    output logic                issueReady,
    output pipeAluPkg::regAddrT rdAddr1,
    output pipeAluPkg::regAddrT rdAddr2,
    input  pipeAluPkg::dataT    rdData1,
    input  pipeAluPkg::dataT    rdData2,
    input  logic                exValid,
    input  pipeAluPkg::regAddrT exDest,
    input  pipeAluPkg::dataT    exResult,
    operandBus.decoder          bus
);
    import pipeAluPkg::*;

    logic hazard;  // offered instr needs the value still in execute
    logic accept;  // handshake this cycle
    dataT op1Sel;  // operand after bypass mux
    dataT op2Sel;

    // instr in execute has no result yet and holds issue for one cycle
    // next cycle it sits in the result register and the bypass covers it
    assign hazard = bus.valid && ((bus.dest == src1) || (bus.dest == src2));
    assign issueReady = !hazard;
    assign accept = issueValid && issueReady;

    // register file read ports follow the offered sources directly
    assign rdAddr1 = src1;
    assign rdAddr2 = src2;

    // bypass from the result register wins over the file
    // file write for that result lands on the same edge we sample
    always_comb begin
        if (exValid && (exDest == src1)) begin
            op1Sel = exResult;
        end else begin
            op1Sel = rdData1;
        end
        if (exValid && (exDest == src2)) begin
            op2Sel = exResult;
        end else begin
            op2Sel = rdData2;
        end
    end

    // valid bit drops to a bubble whenever nothing is accepted
    always_ff @(posedge clock or negedge rstN) begin
        if (!rstN) begin
            bus.valid <= 1'b0;
        end else begin
            bus.valid <= accept;
        end
    end

    // payload only moves on a handshake
    always_ff @(posedge clock) begin
        if (accept) begin
            bus.op   <= opcode;
            bus.op1  <= op1Sel;
            bus.op2  <= op2Sel;
            bus.dest <= dest;
        end
    end

    // an offer reading the dest still in execute must leave a bubble behind
    assert property (@(posedge clock) disable iff (!rstN)
        (issueValid && bus.valid && ((bus.dest == src1) || (bus.dest == src2)))
            |=> !bus.valid)
        else $error("operandDecode: issue taken during hazard");

    // pipe is empty leaving reset and the source may issue at once
    assert property (@(posedge clock) $rose(rstN) |-> issueReady)
        else $error("operandDecode: issueReady low after reset");

endmodule

`default_nettype wire

/* pipeAlu/aluExecute.sv */
// ********************
// execute stage: eight-function ALU
// owns the result register read by write-back, decode and the top ports
// ********************

`default_nettype none

module aluExecute (
    input  logic                clock,
    input  logic                rstN,
    operandBus.executor         bus,
    output logic                exValid,
    output pipeAluPkg::regAddrT exDest,
    output pipeAluPkg::dataT    exResult
);
    import pipeAluPkg::*;

    localparam int MSB = $bits(dataT) - 1;

    dataT aluOut; // combinational ALU result

    always_comb begin
        case (bus.op)
            opAdd:   aluOut = bus.op1 + bus.op2; // carry dropped
            opSub:   aluOut = bus.op1 - bus.op2; // borrow dropped
            opOne:   aluOut = dataT'(1);
            opAnd:   aluOut = bus.op1 & bus.op2;
            opNand:  aluOut = ~(bus.op1 & bus.op2);
            opSrl:   aluOut = {1'b0, bus.op1[MSB:1]};
            opSra:   aluOut = {bus.op1[MSB], bus.op1[MSB:1]}; // sign kept
            opCpa:   aluOut = bus.op1;
            default: aluOut = '0; // op only unknown on a bubble
        endcase
    end

    // valid follows the bus, a bubble clears it
    always_ff @(posedge clock or negedge rstN) begin
        if (!rstN) begin
            exValid <= 1'b0;
        end else begin
            exValid <= bus.valid;
        end
    end

    // result and dest held across bubbles
    always_ff @(posedge clock) begin
        if (bus.valid) begin
            exResult <= aluOut;
            exDest   <= bus.dest;
        end
    end

    // operands come from unreset decode registers, so a valid
    // result must have been built from loaded values only
    assert property (@(posedge clock) disable iff (!rstN)
        exValid |-> !$isunknown(exResult))
        else $error("aluExecute: unknown bits in valid result");

endmodule

`default_nettype wire

/* pipeAlu/writeBack.sv */
// ********************
// result stage: register file with two async read ports
// written from the result register, cleared by reset
// ********************

`default_nettype none

`include "pipeAlu_settings.svh"

module writeBack (
    input  logic                clock,
    input  logic                rstN,
    input  logic                exValid,
    input  pipeAluPkg::regAddrT exDest,
    input  pipeAluPkg::dataT    exResult,
    input  pipeAluPkg::regAddrT rdAddr1,
    input  pipeAluPkg::regAddrT rdAddr2,
    output pipeAluPkg::dataT    rdData1,
    output pipeAluPkg::dataT    rdData2
);
    import pipeAluPkg::*;

    dataT regFile [`PIPEALU_REG_COUNT]; // architectural registers

    // one write per completed instr, two cycles after issue
    always_ff @(posedge clock or negedge rstN) begin
        if (!rstN) begin
            for (int i = 0; i < `PIPEALU_REG_COUNT; i++) begin
                regFile[i] <= '0; // all registers read zero out of reset
            end
        end else if (exValid) begin
            regFile[exDest] <= exResult;
        end
    end

    // reads see the old value on a same-cycle write
    // decode bypasses that case from the result register
    assign rdData1 = regFile[rdAddr1];
    assign rdData2 = regFile[rdAddr2];

    // result register in execute must be empty during reset
    assert property (@(posedge clock) !rstN |-> !exValid)
        else $error("writeBack: write request while in reset");

endmodule

`default_nettype wire

/* rtl/pipeAlu.sv */
// ********************
// top of the three-stage ALU pipeline
// instr in with valid/ready, one result per instr two cycles later
// ********************

`default_nettype none

module pipeAlu (
    input  logic                clock,
    input  logic                rstN,
    input  logic                issueValid,
    input  pipeAluPkg::aluOpT   opcode,
    input  pipeAluPkg::regAddrT src1,
    input  pipeAluPkg::regAddrT src2,
    input  pipeAluPkg::regAddrT dest,
    output logic                issueReady,
    output logic                resultValid,
    output pipeAluPkg::regAddrT resultDest,
    output pipeAluPkg::dataT    result
);
    import pipeAluPkg::*;

    regAddrT rdAddr1; // decode -> register file read addresses
    regAddrT rdAddr2;
    dataT    rdData1; // register file -> decode
    dataT    rdData2;

    operandBus opBus (); // decode to execute

    operandDecode i_decode (
        .clock      (clock),
        .rstN       (rstN),
        .issueValid (issueValid),
        .opcode     (opcode),
        .src1       (src1),
        .src2       (src2),
        .dest       (dest),
        .issueReady (issueReady),
        .rdAddr1    (rdAddr1),
        .rdAddr2    (rdAddr2),
        .rdData1    (rdData1),
        .rdData2    (rdData2),
        .exValid    (resultValid), // bypass source
        .exDest     (resultDest),
        .exResult   (result),
        .bus        (opBus.decoder)
    );

    // result register doubles as the output port
    aluExecute i_execute (
        .clock    (clock),
        .rstN     (rstN),
        .bus      (opBus.executor),
        .exValid  (resultValid),
        .exDest   (resultDest),
        .exResult (result)
    );

    writeBack i_writeBack (
        .clock    (clock),
        .rstN     (rstN),
        .exValid  (resultValid),
        .exDest   (resultDest),
        .exResult (result),
        .rdAddr1  (rdAddr1),
        .rdAddr2  (rdAddr2),
        .rdData1  (rdData1),
        .rdData2  (rdData2)
    );

endmodule

`default_nettype wire

/* verif/pipeAluTb.sv */
// ********************
// testbench for the three-stage ALU pipeline
// directed and LFSR-driven instrs checked against a sequential model
// run with pipeAluTb as top, the DUT sits below as i_dut
// ********************

`default_nettype none

`include "pipeAlu_settings.svh"

module pipeAluTb;
    timeunit 1ns;
    timeprecision 100ps;

    import pipeAluPkg::*;

    localparam int SEED         = 68888;
    localparam int RANDOM_COUNT = 400;  // length of the random stream
    localparam int CYCLE_LIMIT  = 2000; // bound well above directed plus random part
    localparam int DRAIN_LIMIT  = 16;   // ample for a latency of 2

    // one expected completion in issue order
    typedef struct packed {
        regAddrT dest;
        dataT    value;
    } expectT;

    logic    clock;
    logic    rstN;
    logic    issueValid;
    aluOpT   opcode;
    regAddrT src1;
    regAddrT src2;
    regAddrT dest;
    logic    issueReady;
    logic    resultValid;
    regAddrT resultDest;
    dataT    result;

    expectT      pending[$];                    // accepted and not yet completed
    dataT        modelRegs [`PIPEALU_REG_COUNT]; // architectural state of the model
    logic [31:0] lfsrState;
    int          stimEdge       = 0;   // edges seen by the stimulus process
    int          lastAcceptEdge = -10; // far enough back that the first offer sees no hazard
    regAddrT     lastDest       = '0;
    int          acceptCount    = 0;
    int          resultCount    = 0;
    int          valueErrors    = 0;
    int          otherErrors    = 0;
    int          cycleCount     = 0;
    int          drainCycles    = 0;

    pipeAlu i_dut (
        .clock       (clock),
        .rstN        (rstN),
        .issueValid  (issueValid),
        .opcode      (opcode),
        .src1        (src1),
        .src2        (src2),
        .dest        (dest),
        .issueReady  (issueReady),
        .resultValid (resultValid),
        .resultDest  (resultDest),
        .result      (result)
    );

    initial begin
        clock = 1'b0;
        forever #2 clock = ~clock; // 4 ns period
    end

    // sequential semantics of each opcode
    function automatic dataT aluRef(input aluOpT op, input dataT a, input dataT b);
        case (op)
            opAdd:   return a + b; // wraps at word width
            opSub:   return a - b;
            opOne:   return dataT'(1);
            opAnd:   return a & b;
            opNand:  return ~(a & b);
            opSrl:   return a >> 1;
            opSra:   return dataT'($signed(a) >>> 1); // sign bit replicated
            default: return a; // opCpa
        endcase
    endfunction

    // right-shift Galois form with taps 32 31 29 1
    function automatic logic [31:0] lfsrNext(input logic [31:0] state);
        logic [31:0] next;
        next = state >> 1;
        if (state[0]) begin
            next = next ^ 32'hD000_0001;
        end
        return next;
    endfunction

    // one LFSR step per bit taken
    function automatic int unsigned takeBits(input int count);
        int unsigned value;
        value = 0;
        for (int i = 0; i < count; i++) begin
            lfsrState = lfsrNext(lfsrState);
            value = (value << 1) | {31'b0, lfsrState[0]};
        end
        return value;
    endfunction

    task automatic tick();
        @(posedge clock);
        stimEdge++;
    endtask

    // source drops valid for a number of cycles
    task automatic idle(input int cycles);
        issueValid <= 1'b0;
        repeat (cycles) tick();
    endtask

    // hold one instr until accepted and then update the model
    task automatic offer(input aluOpT op, input regAddrT s1, input regAddrT s2,
                         input regAddrT d);
        int     stalls;
        int     expStalls;
        expectT entry;
        stalls = 0;
        issueValid <= 1'b1;
        opcode     <= op;
        src1       <= s1;
        src2       <= s2;
        dest       <= d;
        tick();
        // prior instr accepted one edge ago still sits in execute
        if ((lastAcceptEdge == stimEdge - 1) && ((lastDest == s1) || (lastDest == s2))) begin
            expStalls = 1;
        end else begin
            expStalls = 0;
        end
        while (!issueReady) begin
            stalls++;
            tick();
        end
        assert (stalls == expStalls) else begin
            $display("FAILED at %0t: issueReady stall cycles expected %0d, got %0d",
                     $time, expStalls, stalls);
            valueErrors++;
        end
        lastAcceptEdge = stimEdge;
        lastDest = d;
        entry.dest  = d;
        entry.value = aluRef(op, modelRegs[s1], modelRegs[s2]);
        modelRegs[d] = entry.value;
        pending.push_back(entry);
        acceptCount++;
    endtask

    // random fields with an occasional short gap after the instr
    task automatic randomOffer();
        aluOpT   op;
        regAddrT s1;
        regAddrT s2;
        regAddrT d;
        op = aluOpT'(3'(takeBits(3)));
        s1 = regAddrT'(takeBits(2));
        s2 = regAddrT'(takeBits(2));
        d  = regAddrT'(takeBits(2));
        offer(op, s1, s2, d);
        if (takeBits(3) == 0) begin
            idle(1 + int'(takeBits(1)));
        end
    endtask

    // every result must match the oldest outstanding instr
    initial begin : compareResults
        expectT expected;
        forever begin
            @(posedge clock);
            if (resultValid) begin
                resultCount++;
                assert (pending.size() != 0) else begin
                    $display("result for register %0d arrived with nothing outstanding at %0t",
                             resultDest, $time);
                    otherErrors++;
                end
                if (pending.size() != 0) begin
                    expected = pending.pop_front();
                    assert (resultDest == expected.dest) else begin
                        $display("FAILED at %0t: resultDest expected %0d, got %0d",
                                 $time, expected.dest, resultDest);
                        valueErrors++;
                    end
                    assert (result == expected.value) else begin
                        $display("FAILED at %0t: result expected 0x%h, got 0x%h",
                                 $time, expected.value, result);
                        valueErrors++;
                    end
                end
            end
        end
    end

    initial begin : watchdog
        while (cycleCount < CYCLE_LIMIT) begin
            @(posedge clock);
            cycleCount++;
        end
        $display("timeout: run did not finish within %0d cycles", CYCLE_LIMIT);
        $display("errors: %0d value, %0d other", valueErrors, otherErrors);
        $display("TEST FAILED");
        $finish;
    end

    initial begin : stimulus
        rstN       = 1'b0;
        issueValid = 1'b0;
        opcode     = opAdd;
        src1       = '0;
        src2       = '0;
        dest       = '0;
        lfsrState  = 32'(SEED);
        for (int i = 0; i < `PIPEALU_REG_COUNT; i++) begin
            modelRegs[i] = '0; // DUT clears its file on reset
        end

        repeat (3) tick();
        rstN <= 1'b1;
        tick();
        assert (!resultValid) else begin
            $display("FAILED at %0t: resultValid expected 0, got %0b", $time, resultValid);
            valueErrors++;
        end
        assert (issueReady) else begin
            $display("FAILED at %0t: issueReady expected 1, got %0b", $time, issueReady);
            valueErrors++;
        end

        // all registers read zero after reset
        for (int r = 0; r < `PIPEALU_REG_COUNT; r++) begin
            offer(opCpa, regAddrT'(r), regAddrT'(r), regAddrT'(r));
        end
        idle(2);

        // constants and each opcode including wrap and the sign-keeping shift
        offer(opOne, 2'd0, 2'd0, 2'd0);
        offer(opOne, 2'd1, 2'd1, 2'd1);
        offer(opAdd, 2'd0, 2'd1, 2'd2);
        offer(opAdd, 2'd2, 2'd2, 2'd3);
        offer(opSub, 2'd0, 2'd3, 2'd0);  // 1 - 4 wraps below zero
        offer(opSra, 2'd0, 2'd0, 2'd1);  // negative word stays negative
        offer(opSrl, 2'd0, 2'd0, 2'd2);
        offer(opAnd, 2'd1, 2'd2, 2'd3);
        offer(opNand, 2'd1, 2'd2, 2'd0);
        offer(opCpa, 2'd3, 2'd0, 2'd1);
        offer(opAdd, 2'd0, 2'd0, 2'd2);  // carry out dropped
        for (int k = 0; k < 8; k++) begin
            offer(aluOpT'(3'(k)), regAddrT'(takeBits(2)), regAddrT'(takeBits(2)),
                  regAddrT'(takeBits(2)));
        end
        idle(1);

        // back-to-back dependence stalls once and then takes the bypass
        offer(opSub, 2'd3, 2'd3, 2'd3);  // file holds zero, only the bypass has the one
        offer(opOne, 2'd0, 2'd0, 2'd3);
        offer(opAdd, 2'd3, 2'd3, 2'd3);
        // dependence two apart needs no stall and uses the result-stage bypass
        offer(opAdd, 2'd1, 2'd2, 2'd0);
        offer(opCpa, 2'd1, 2'd1, 2'd1);
        offer(opSub, 2'd0, 2'd2, 2'd2);
        idle(3); // no results expected from idle cycles

        repeat (RANDOM_COUNT) randomOffer();
        issueValid <= 1'b0;

        // wait for the outstanding results to drain
        while ((pending.size() != 0) && (drainCycles < DRAIN_LIMIT)) begin
            @(negedge clock);
            drainCycles++;
        end
        repeat (4) @(negedge clock); // any stray result lands here
        assert (pending.size() == 0) else begin
            $display("%0d instructions never produced a result", pending.size());
            otherErrors++;
        end
        assert (resultCount == acceptCount) else begin
            $display("%0d results seen for %0d accepted instructions", resultCount, acceptCount);
            otherErrors++;
        end

        $display("errors: %0d value, %0d other; %0d accepted, %0d completed",
                 valueErrors, otherErrors, acceptCount, resultCount);
        if ((valueErrors == 0) && (otherErrors == 0)) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* verilog.f */
+incdir+common
common/pipeAluPkg.sv
common/operandBus.sv
pipeAlu/operandDecode.sv
pipeAlu/aluExecute.sv
pipeAlu/writeBack.sv
rtl/pipeAlu.sv
verif/pipeAluTb.sv

/* Makefile */
# Verilator build for the pipelined ALU testbench

TOP := pipeAluTb

.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only --timing --assert -f verilog.f --top-module pipeAlu
	verilator --lint-only --timing --assert -f verilog.f --top-module $(TOP)

# exit status comes from grep, so a run without the pass line fails
sim:
	verilator --binary --timing --assert -j 0 -f verilog.f --top-module $(TOP) -o simv
	./obj_dir/simv | tee /dev/stderr | grep -q "^TEST PASSED$$"

clean:
	rm -rf obj_dir
